/* flist.f */
+incdir+include
design/alink_pkg.sv
design/alink_regs.sv
design/task_fifo.sv
design/tx_serializer.sv
design/alink_top.sv
testbench/alink_assert.sv
testbench/tb_alink.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and check the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_alink -f flist.f -o sim_alink \
    && ./obj_dir/sim_alink > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^No errors$" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* testbench/tb_alink.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alink_settings.svh"

module tb_alink;

    import alink_pkg::*;

    localparam int PHY          = `ALINK_PHY_NUM;
    localparam int TASK_LEN     = `ALINK_TASK_LEN;
    localparam int TASK_BITS    = TASK_LEN * 32;
    localparam int DEPTH        = `ALINK_FIFO_DEPTH;
    localparam int CNT_W        = `ALINK_CNT_W;
    localparam int BUS_TIMEOUT  = 20;     // Cycles per access
    localparam int TASK_TIMEOUT = 3000;   // Cycles per drain
    localparam logic [5:0] ADR_TXDATA = 6'(`ALINK_ADR_TXDATA);
    localparam logic [5:0] ADR_CTRL   = 6'(`ALINK_ADR_CTRL);
    localparam logic [5:0] ADR_STATUS = 6'(`ALINK_ADR_STATUS);

    // Decoded task and the lane it came from
    typedef struct packed {
        lane_vec_t            lane;
        logic [TASK_BITS-1:0] data;
    } rx_task_t;

    logic        rx_almost_full;   // Clock
    logic        reset;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    lane_vec_t   tx_p;
    lane_vec_t   tx_n;
    logic [31:0] exp_q [$];        // Accepted words not yet seen on a lane
    rx_task_t    got_q [$];        // Filled by the lane decoders
    lane_vec_t   mask_m;           // Mask as last written
    int          last_lane_m;      // Model round-robin pointer
    int          fifo_words;       // Words the model expects queued
    int          word_errs;
    int          lane_errs;
    int          status_errs;
    int          other_errs;
    integer      seed;
    status_t     st;               // Last status read
    int          n;

    alink_top i_dut (
        .rx_almost_full (rx_almost_full),
        .reset          (reset),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .tx_p           (tx_p),
        .tx_n           (tx_n)
    );

    initial begin
        rx_almost_full = 1'b0;
        forever #5 rx_almost_full = ~rx_almost_full;
    end

    // ----------------------------------------
    // Reference model and compare tasks
    // ----------------------------------------
    // Next unmasked lane after prev in rising order with wrap
    function automatic int expect_lane(input int prev, input lane_vec_t mask);
        int cand;
        for (int i = 1; i <= PHY; i++) begin
            cand = (prev + i) % PHY;
            if (mask[cand]) begin
                return cand;
            end
        end
        return prev;   // Zero mask picks nothing
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input int k);
        if (got !== exp) begin
            $display("ERROR %0t: task word %0d got %h expected %h", $time, k, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_lane(input lane_vec_t got, input lane_vec_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s lane got %b expected %b", $time, what, got, exp);
            lane_errs++;
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s status got count %0d af %b busy %b, expected %0d %b %b",
                     $time, what, got.count, got.almost_full, got.busy,
                     exp.count, exp.almost_full, exp.busy);
            status_errs++;
        end
    endtask

    // ----------------------------------------
    // Bus access
    // ----------------------------------------
    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                              output logic [31:0] rd);
        int waited;
        @(negedge rx_almost_full);
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.adr = adr;
        bus_req.dat = dat;
        waited = 0;
        do begin
            @(negedge rx_almost_full);
            waited++;
        end while (!bus_rsp.ack && waited < BUS_TIMEOUT);
        if (!bus_rsp.ack) begin
            $display("Bus access to address %0d was never acknowledged", adr);
            other_errs++;
        end
        rd      = bus_rsp.dat;   // Valid with ack
        bus_req = '0;
    endtask

    task automatic bus_write(input logic [5:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [5:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic read_status();
        logic [31:0] rd;
        bus_read(ADR_STATUS, rd);
        st = status_t'(rd);
    endtask

    // Word is kept only while there is room for a whole task
    task automatic push_word(input logic [31:0] w);
        bus_write(ADR_TXDATA, w);
        if (fifo_words + TASK_LEN <= DEPTH) begin
            exp_q.push_back(w);
            fifo_words++;
        end
    endtask

    task automatic send_task();
        repeat (TASK_LEN) push_word($random(seed));
    endtask

    task automatic write_ctrl(input logic flush, input lane_vec_t mask);
        ctrl_word_u  cw;
        logic [31:0] rd;
        cw.raw        = '0;
        cw.ctrl.flush = flush;
        cw.ctrl.mask  = mask;
        bus_write(ADR_CTRL, cw.raw);
        mask_m = mask;
        if (flush) begin
            exp_q.delete();   // Flushed words must never show up
            fifo_words = 0;
        end
        // Mask reads back as written
        bus_read(ADR_CTRL, rd);
        cw.raw = rd;
        check_lane(cw.ctrl.mask, mask, "mask readback");
    endtask

    // Idle status with count and flag from the model
    task automatic expect_status(input string what);
        status_t exp_st;
        exp_st             = '0;
        exp_st.count       = CNT_W'(fifo_words);
        exp_st.almost_full = (fifo_words + TASK_LEN > DEPTH);
        read_status();
        check_status(st, exp_st, what);
    endtask

    // Wait for every written task decoded and every lane idle
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TASK_TIMEOUT) begin
            @(negedge rx_almost_full);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d written words never sent", exp_q.size());
            other_errs++;
        end
        waited = 0;
        do begin
            read_status();
            waited++;
        end while (st.busy != '0 && waited < BUS_TIMEOUT);
        if (st.busy != '0) begin
            $display("Timed out waiting for the lanes to go idle");
            other_errs++;
        end
    endtask

    // ----------------------------------------
    // Lane decoders and compare process
    // ----------------------------------------
    for (genvar g = 0; g < PHY; g++) begin : g_lane_dec
        logic [TASK_BITS-1:0] shift;
        int                   nbits;
        rx_task_t             dec_task;
        always @(negedge rx_almost_full) begin
            if (reset) begin
                nbits = 0;
            end else if (tx_p[g] || tx_n[g]) begin
                shift = {shift[TASK_BITS-2:0], tx_p[g]};   // MSB first
                nbits = nbits + 1;
                if (nbits == TASK_BITS) begin
                    dec_task.lane = lane_vec_t'(1) << g;
                    dec_task.data = shift;
                    got_q.push_back(dec_task);
                    nbits = 0;
                end
            end
        end
    end

    always @(negedge rx_almost_full) begin : compare_proc
        rx_task_t t;
        int       exp_l;
        if (!reset && got_q.size() != 0) begin
            t = got_q.pop_front();
            if (exp_q.size() < TASK_LEN) begin
                $display("A task arrived on lanes %b with no matching words written", t.lane);
                other_errs++;
            end else begin
                for (int k = 0; k < TASK_LEN; k++) begin
                    check_word(t.data[TASK_BITS-1-32*k -: 32], exp_q.pop_front(), k);
                end
                exp_l = expect_lane(last_lane_m, mask_m);
                check_lane(t.lane, lane_vec_t'(1) << exp_l, "task");
                last_lane_m = exp_l;
                fifo_words  = fifo_words - TASK_LEN;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        seed        = 66206;
        word_errs   = 0;
        lane_errs   = 0;
        status_errs = 0;
        other_errs  = 0;
        mask_m      = '0;
        last_lane_m = PHY - 1;   // Search starts at lane 0
        fifo_words  = 0;
        reset       = 1'b1;
        bus_req     = '0;
        repeat (2) @(negedge rx_almost_full);
        reset = 1'b0;

        // Five tasks over all lanes in turn
        write_ctrl(1'b0, '1);
        repeat (5) send_task();
        wait_drained();
        expect_status("after round robin");

        // Lanes 1 and 3 only
        write_ctrl(1'b0, lane_vec_t'(4'b1010));
        repeat (4) send_task();
        wait_drained();

        // Zero mask holds tasks while count grows
        write_ctrl(1'b0, '0);
        repeat (2 * TASK_LEN) begin
            push_word($random(seed));
            expect_status("held write");
        end
        write_ctrl(1'b0, '1);
        wait_drained();
        expect_status("after release");

        // Fill to almost-full and check that later writes are dropped
        write_ctrl(1'b0, '0);
        n = 0;
        do begin
            push_word($random(seed));
            expect_status("fill");
            n++;
        end while (!st.almost_full && n <= DEPTH);
        if (!st.almost_full) begin
            $display("Almost-full never came up while filling the FIFO");
            other_errs++;
        end
        repeat (3) begin
            push_word($random(seed));
            expect_status("write when almost full");
        end

        // Flush followed by one fresh task
        write_ctrl(1'b1, '0);
        expect_status("after flush");
        write_ctrl(1'b0, '1);
        send_task();
        wait_drained();

        // Busy seen in flight and idle afterwards
        send_task();
        n = 0;
        do begin
            read_status();
            n++;
        end while (st.busy == '0 && n < BUS_TIMEOUT);
        check_lane(st.busy, lane_vec_t'(1) << expect_lane(last_lane_m, mask_m), "busy");
        wait_drained();
        expect_status("after busy falls");

        if (got_q.size() != 0) begin
            $display("Decoded tasks left over with no words expected");
            other_errs++;
        end
        $display("Error counts: word %0d, lane %0d, status %0d, other %0d",
                 word_errs, lane_errs, status_errs, other_errs);
        if (word_errs + lane_errs + status_errs + other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/alink_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alink_settings.svh"

module alink_assert (
    input wire logic                    rx_almost_full, // Clock
    input wire logic                    reset,
    input wire alink_pkg::bus_rsp_t     bus_rsp,
    input wire alink_pkg::lane_vec_t    tx_p,
    input wire alink_pkg::lane_vec_t    tx_n,
    input wire alink_pkg::lane_vec_t    lane_busy,
    input wire logic                    pop,
    input wire logic [`ALINK_CNT_W-1:0] count
);

    // ----------------------------------------
    // Bus and lane protocol
    // ----------------------------------------
    ack_one_cycle: assert property (@(posedge rx_almost_full) disable iff (reset)
        bus_rsp.ack |=> !bus_rsp.ack)
        else $error("Bus acknowledge held for more than one cycle");

    // Dual-rail, one rail per bit
    p_n_exclusive: assert property (@(posedge rx_almost_full) disable iff (reset)
        (tx_p & tx_n) == '0)
        else $error("P and N high together on a lane");

    one_lane_busy: assert property (@(posedge rx_almost_full) disable iff (reset)
        $onehot0(lane_busy))
        else $error("More than one lane busy");

    no_pop_empty: assert property (@(posedge rx_almost_full) disable iff (reset)
        pop |-> count != '0)
        else $error("Pop with an empty FIFO");

endmodule

bind alink_top alink_assert i_assert (
    .rx_almost_full (rx_almost_full),
    .reset          (reset),
    .bus_rsp        (bus_rsp),
    .tx_p           (tx_p),
    .tx_n           (tx_n),
    .lane_busy      (lane_busy),
    .pop            (pop),
    .count          (count)
);

`default_nettype wire

/* design/alink_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alink_settings.svh"

module alink_top (
    input  wire logic                 rx_almost_full, // Clock
    input  wire logic                 reset,
    input  wire alink_pkg::bus_req_t  bus_req,
    output alink_pkg::bus_rsp_t       bus_rsp,
    output alink_pkg::lane_vec_t      tx_p,
    output alink_pkg::lane_vec_t      tx_n
);

    import alink_pkg::*;

    logic                    push;
    logic [31:0]             push_data;
    logic                    flush;
    logic                    pop;
    logic [31:0]             pop_data;
    logic [`ALINK_CNT_W-1:0] count;      // Seen by regs and serializer
    lane_vec_t               lane_mask;
    lane_vec_t               lane_busy;

    // ----------------------------------------
    // Host side registers
    // ----------------------------------------
    alink_regs i_regs (
        .rx_almost_full (rx_almost_full),
        .reset          (reset),
        .bus_req        (bus_req),
        .count          (count),
        .lane_busy      (lane_busy),   // Status only
        .bus_rsp        (bus_rsp),
        .push           (push),
        .push_data      (push_data),
        .flush          (flush),
        .lane_mask      (lane_mask)
    );

    // Task word queue
    task_fifo i_fifo (
        .rx_almost_full (rx_almost_full),
        .reset          (reset),
        .flush          (flush),
        .push           (push),
        .push_data      (push_data),
        .pop            (pop),
        .pop_data       (pop_data),
        .count          (count)
    );

    // ----------------------------------------
    // Lane side
    // ----------------------------------------
    tx_serializer i_ser (
        .rx_almost_full (rx_almost_full),
        .reset          (reset),
        .lane_mask      (lane_mask),
        .count          (count),
        .pop_data       (pop_data),
        .pop            (pop),
        .lane_busy      (lane_busy),
        .tx_p           (tx_p),
        .tx_n           (tx_n)
    );

endmodule

`default_nettype wire

/* design/tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alink_settings.svh"

module tx_serializer (
    input  wire logic                    rx_almost_full, // Clock
    input  wire logic                    reset,
    input  wire alink_pkg::lane_vec_t    lane_mask,
    input  wire logic [`ALINK_CNT_W-1:0] count,
    input  wire logic [31:0]             pop_data,
    output logic                         pop,
    output alink_pkg::lane_vec_t         lane_busy,
    output alink_pkg::lane_vec_t         tx_p,
    output alink_pkg::lane_vec_t         tx_n
);

    import alink_pkg::*;

    localparam int PHY       = `ALINK_PHY_NUM;
    localparam int CNT_W     = `ALINK_CNT_W;
    localparam int TASK_LEN  = `ALINK_TASK_LEN;
    localparam int TASK_BITS = TASK_LEN * 32;
    localparam int LANE_W    = (PHY > 1) ? $clog2(PHY) : 1;
    localparam int WORD_W    = (TASK_LEN > 1) ? $clog2(TASK_LEN) : 1;
    localparam int BIT_W     = $clog2(TASK_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,   // One pop per cycle
        ST_SHIFT   // Pulse cycle then idle cycle per bit
    } state_t;

    state_t               state;
    logic [LANE_W-1:0]    last_lane;  // Lane of previous task
    logic [LANE_W-1:0]    next_lane;
    lane_vec_t            lane_sel;   // One-hot, current task
    logic [TASK_BITS-1:0] sreg;       // Whole task, first word on top
    logic [BIT_W-1:0]     bit_cnt;    // Bits left after current
    logic [WORD_W-1:0]    word_cnt;
    logic                 phase;      // 0 = pulse, 1 = gap
    logic                 start;
    logic                 cur_bit;

    // ----------------------------------------
    // Round-robin lane pick
    // ----------------------------------------
    // Walk down so the nearest unmasked lane after last_lane wins
    always_comb begin
        int cand;
        next_lane = last_lane;
        for (int i = PHY; i >= 1; i--) begin
            cand = (int'(last_lane) + i) % PHY;
            if (lane_mask[cand]) begin
                next_lane = LANE_W'(cand);
            end
        end
    end

    assign start = (state == ST_IDLE) && (count >= CNT_W'(TASK_LEN)) && (lane_mask != '0);
    assign pop   = (state == ST_LOAD) && (count != '0);   // Never on empty FIFO

    // ----------------------------------------
    // Lane outputs
    // ----------------------------------------
    assign cur_bit   = sreg[TASK_BITS-1];   // MSB first
    assign lane_busy = (state != ST_IDLE) ? lane_sel : '0;
    assign tx_p      = (state == ST_SHIFT && !phase && cur_bit)  ? lane_sel : '0;
    assign tx_n      = (state == ST_SHIFT && !phase && !cur_bit) ? lane_sel : '0;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge rx_almost_full) begin
        if (reset) begin
            state     <= ST_IDLE;
            last_lane <= LANE_W'(PHY - 1);  // First search hits lane 0
            lane_sel  <= '0;
            word_cnt  <= '0;
            bit_cnt   <= '0;
            phase     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        last_lane <= next_lane;
                        lane_sel  <= lane_vec_t'(1'b1) << next_lane;
                        word_cnt  <= '0;
                        state     <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (count == '0) begin
                        state <= ST_IDLE;   // Flushed before fully loaded, task gone
                    end else if (word_cnt == WORD_W'(TASK_LEN - 1)) begin
                        bit_cnt <= BIT_W'(TASK_BITS - 1);
                        phase   <= 1'b0;
                        state   <= ST_SHIFT;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                ST_SHIFT: begin
                    if (!phase) begin
                        phase <= 1'b1;
                    end else begin
                        phase <= 1'b0;
                        if (bit_cnt == '0) begin
                            state <= ST_IDLE;   // Busy drops after last gap
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift register, loaded word by word then shifted in the gap cycle
    always_ff @(posedge rx_almost_full) begin
        if (pop) begin
            sreg <= (sreg << 32) | TASK_BITS'(pop_data);
        end else if (state == ST_SHIFT && phase) begin
            sreg <= sreg << 1;
        end
    end

endmodule

`default_nettype wire

/* design/task_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alink_settings.svh"

module task_fifo (
    input  wire logic                    rx_almost_full, // Clock
    input  wire logic                    reset,
    input  wire logic                    flush,          // Sync clear
    input  wire logic                    push,
    input  wire logic [31:0]             push_data,
    input  wire logic                    pop,
    output logic [31:0]                  pop_data,       // Head, first-word-fall-through
    output logic [`ALINK_CNT_W-1:0]      count
);

    localparam int DEPTH = `ALINK_FIFO_DEPTH;
    localparam int CNT_W = `ALINK_CNT_W;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [31:0]      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;    // Overflow ignored
    assign do_pop  = pop && !empty;    // Underflow ignored

    assign pop_data = mem[rd_ptr];

    // ----------------------------------------
    // Pointers and count
    // ----------------------------------------
    always_ff @(posedge rx_almost_full) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;   // Flush empties at once
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge rx_almost_full) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* design/alink_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alink_settings.svh"

module alink_regs (
    input  wire logic                    rx_almost_full, // Clock
    input  wire logic                    reset,
    input  wire alink_pkg::bus_req_t     bus_req,
    input  wire logic [`ALINK_CNT_W-1:0] count,
    input  wire alink_pkg::lane_vec_t    lane_busy,
    output alink_pkg::bus_rsp_t          bus_rsp,
    output logic                         push,
    output logic [31:0]                  push_data,
    output logic                         flush,
    output alink_pkg::lane_vec_t         lane_mask
);

    import alink_pkg::*;

    localparam logic [5:0] ADR_TXDATA = 6'(`ALINK_ADR_TXDATA);
    localparam logic [5:0] ADR_CTRL   = 6'(`ALINK_ADR_CTRL);
    localparam logic [5:0] ADR_STATUS = 6'(`ALINK_ADR_STATUS);

    ctrl_word_u  wr_word;     // Incoming write word, two views
    ctrl_word_u  rd_ctrl;     // Mask readback
    status_t     status;
    logic        access;      // New strobe sampled this cycle
    logic        wr_txdata;
    logic        wr_ctrl;
    logic        almost_full;
    logic        ack_q;
    logic [31:0] rd_mux;
    logic [31:0] rd_data_q;

    // ----------------------------------------
    // Access decode
    // ----------------------------------------
    // Strobe is ignored during the ack cycle so each access counts once
    assign access    = bus_req.stb && !ack_q;
    assign wr_txdata = access && bus_req.we && (bus_req.adr == ADR_TXDATA);
    assign wr_ctrl   = access && bus_req.we && (bus_req.adr == ADR_CTRL);
    assign wr_word.raw = bus_req.dat;

    // Room check for a whole task
    // Pending push is counted, FIFO count lags it by one cycle
    assign almost_full = (32'(count) + 32'(push) + `ALINK_TASK_LEN) > `ALINK_FIFO_DEPTH;

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    always_comb begin
        status             = '0;
        status.count       = count;
        status.almost_full = almost_full;
        status.busy        = lane_busy;

        rd_ctrl           = '0;
        rd_ctrl.ctrl.mask = lane_mask; // Flush reads back as 0

        case (bus_req.adr)
            ADR_STATUS: rd_mux = status;
            ADR_CTRL:   rd_mux = rd_ctrl.raw;
            default:    rd_mux = '0;     // TXDATA is write only
        endcase
    end

    assign bus_rsp.ack = ack_q;
    assign bus_rsp.dat = rd_data_q;

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge rx_almost_full) begin
        if (reset) begin
            ack_q     <= 1'b0;
            push      <= 1'b0;
            flush     <= 1'b0;
            lane_mask <= '0;   // Holds tasks until host enables lanes
        end else begin
            ack_q <= access;                       // One cycle after strobe
            push  <= wr_txdata && !almost_full;    // Word dropped when full
            flush <= wr_ctrl && wr_word.ctrl.flush;
            if (wr_ctrl) begin
                lane_mask <= wr_word.ctrl.mask;
            end
        end
    end

    // Payload registers
    always_ff @(posedge rx_almost_full) begin
        if (access && bus_req.we) begin
            push_data <= wr_word.raw;
        end
        if (access && !bus_req.we) begin
            rd_data_q <= rd_mux;   // Shown with ack
        end
    end

endmodule

`default_nettype wire

/* design/alink_pkg.sv */
`default_nettype none
`include "alink_settings.svh"

package alink_pkg;

    // One bit per lane, used for mask and busy
    typedef logic [`ALINK_PHY_NUM-1:0] lane_vec_t;

    // ----------------------------------------
    // Register bus
    // ----------------------------------------
    typedef struct packed {
        logic        stb;   // Held until ack
        logic        we;    // 1 = write
        logic [5:0]  adr;   // Word address
        logic [31:0] dat;   // Write data
    } bus_req_t;

    typedef struct packed {
        logic        ack;   // Single-cycle pulse
        logic [31:0] dat;   // Valid with ack on reads
    } bus_rsp_t;

    // ----------------------------------------
    // Control word
    // ----------------------------------------
    // Flush sits at bit 0, mask right above it
    typedef struct packed {
        logic [31-`ALINK_PHY_NUM-1:0] rsvd;
        lane_vec_t                    mask;
        logic                         flush;
    } ctrl_fields_t;

    // Same write word seen as task data or as control fields
    typedef union packed {
        logic [31:0]  raw;
        ctrl_fields_t ctrl;
    } ctrl_word_u;

    // ----------------------------------------
    // Status word
    // ----------------------------------------
    typedef struct packed {
        logic [31-`ALINK_CNT_W-1-`ALINK_PHY_NUM:0] rsvd;
        lane_vec_t                                 busy;        // Per lane
        logic                                      almost_full; // No room for a task
        logic [`ALINK_CNT_W-1:0]                   count;       // FIFO words
    } status_t;

endpackage

`default_nettype wire

/* include/alink_settings.svh */
`ifndef ALINK_SETTINGS_SVH
`define ALINK_SETTINGS_SVH

// ----------------------------------------
// Link geometry
// ----------------------------------------
`define ALINK_PHY_NUM     4   // Downstream lanes
`define ALINK_TASK_LEN    2   // Words per task

// ----------------------------------------
// Task FIFO
// ----------------------------------------
`define ALINK_FIFO_DEPTH  16  // Words
`define ALINK_CNT_W       5   // Count width, must hold DEPTH itself

// ----------------------------------------
// Register map
// ----------------------------------------
// Word addresses on the 6-bit register bus
`define ALINK_ADR_TXDATA  0   // Task word push, write only
`define ALINK_ADR_CTRL    1   // Flush and lane mask
`define ALINK_ADR_STATUS  2   // Count, almost-full, busy

`endif
